// ==== fp_pkg.sv ====
package fp_pkg;

    // Number of register stages from request to result.
    localparam int FMA_LATENCY = 3;

    localparam logic [31:0] FP32_ONE  = 32'h3f800000;
    localparam logic [31:0] FP32_QNAN = 32'h7fc00000;

    ////////////////////
    // Float word

    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } fp32_fields_t;

    // The formatter works on the raw bits, the lane on the decoded fields.
    typedef union packed {
        logic [31:0]  raw;
        fp32_fields_t fields;
    } fp32_t;

    ////////////////////
    // Control codes

    typedef enum logic [2:0] {
        ADD   = 3'd0,
        SUB   = 3'd1,
        MUL   = 3'd2,
        MADD  = 3'd3,
        MSUB  = 3'd4,
        NMADD = 3'd5,
        NMSUB = 3'd6
    } fp_op_t;

    typedef logic [2:0] frm_t;

    // Any code other than RTZ rounds to nearest even.
    localparam frm_t RNE = 3'd0;
    localparam frm_t RTZ = 3'd1;

    typedef struct packed {
        logic nv;
        logic dz;
        logic of;
        logic uf;
        logic nx;
    } fflags_t;

    ////////////////////
    // Lane request

    // Every operation reaches the lane as a * b + c.
    typedef struct packed {
        fp32_t a;
        fp32_t b;
        fp32_t c;
        frm_t  frm;
    } lane_req_t;

endpackage

// ==== fp_operand_fmt.sv ====
module fp_operand_fmt import fp_pkg::*; #(
    parameter int LANES = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   enable,
    input  fp_op_t                 op,
    input  frm_t                   frm,
    input  fp32_t     [LANES-1:0]  dataa,
    input  fp32_t     [LANES-1:0]  datab,
    input  fp32_t     [LANES-1:0]  datac,
    output lane_req_t [LANES-1:0]  req
);

    fp32_t [LANES-1:0] fmt_a;
    fp32_t [LANES-1:0] fmt_b;
    fp32_t [LANES-1:0] fmt_c;

    fp32_t [LANES-1:0] a_q;
    fp32_t [LANES-1:0] b_q;
    fp32_t [LANES-1:0] c_q;
    frm_t              frm_q;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            fmt_a[i] = dataa[i];
            fmt_b[i] = datab[i];
            fmt_c[i] = datac[i];
            case (op)
                ADD, SUB: begin
                    // 1.0 * a + b keeps the sum exact in the multiplier.
                    fmt_a[i].raw = FP32_ONE;
                    fmt_b[i] = dataa[i];
                    fmt_c[i].raw = {datab[i].raw[31] ^ (op == SUB), datab[i].raw[30:0]};
                end
                MUL: begin
                    // A zero addend with the product's sign leaves a zero product as it is.
                    fmt_c[i].raw = {dataa[i].raw[31] ^ datab[i].raw[31], 31'd0};
                end
                MSUB: begin
                    fmt_c[i].raw[31] = ~datac[i].raw[31];
                end
                NMADD: begin
                    fmt_a[i].raw[31] = ~dataa[i].raw[31];
                    fmt_c[i].raw[31] = ~datac[i].raw[31];
                end
                NMSUB: begin
                    fmt_a[i].raw[31] = ~dataa[i].raw[31];
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            a_q <= fmt_a;
            b_q <= fmt_b;
            c_q <= fmt_c;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            frm_q <= RNE;
        end else if (enable) begin
            frm_q <= frm;
        end
    end

    for (genvar i = 0; i < LANES; i++) begin : g_req
        assign req[i] = '{a: a_q[i], b: b_q[i], c: c_q[i], frm: frm_q};
    end

endmodule

// ==== fp_fma_lane.sv ====
module fp_fma_lane import fp_pkg::*; (
    input  logic      clk,
    input  logic      enable,
    input  lane_req_t req,
    output fp32_t     result,
    output fflags_t   fflags
);

    // Fixed-point frame for both terms, unit weight at bit FW-2.
    localparam int FW = 76;

    typedef struct packed {
        logic        zero;
        logic        inf;
        logic        nan;
        logic        snan;
        logic [23:0] sig;
    } opnd_t;

    function automatic opnd_t decode(input fp32_t x);
        opnd_t d;
        d.zero = (x.fields.exponent == 8'd0);
        d.inf  = (x.fields.exponent == 8'hff) && (x.fields.mantissa == 23'd0);
        d.nan  = (x.fields.exponent == 8'hff) && (x.fields.mantissa != 23'd0);
        d.snan = d.nan && !x.fields.mantissa[22];
        d.sig  = d.zero ? 24'd0 : {1'b1, x.fields.mantissa};
        return d;
    endfunction

    function automatic logic [6:0] count_lz(input logic [FW:0] v);
        logic [6:0] n;
        logic       found;
        n     = 7'(FW + 1);
        found = 1'b0;
        for (int i = FW; i >= 0; i--) begin
            if (!found && v[i]) begin
                n     = 7'(FW - i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    ////////////////////
    // Stage 1: multiply and align

    opnd_t              op_a, op_b, op_c;
    logic               sign_p, sign_c;
    logic               prod_zero, prod_nan, prod_inf, prod_big;
    logic [47:0]        prod_sig;
    logic signed [11:0] exp_p, exp_c, exp_diff, exp_abs;
    logic [6:0]         shamt;
    logic [FW-1:0]      frame_p, frame_c, frame_small, shifted, lost;

    always_comb begin
        op_a      = decode(req.a);
        op_b      = decode(req.b);
        op_c      = decode(req.c);
        sign_p    = req.a.fields.sign ^ req.b.fields.sign;
        sign_c    = req.c.fields.sign;
        prod_zero = op_a.zero | op_b.zero;
        prod_nan  = op_a.nan | op_b.nan | (op_a.inf & op_b.zero) | (op_a.zero & op_b.inf);
        prod_inf  = (op_a.inf | op_b.inf) & ~prod_nan;
        prod_sig  = op_a.sig * op_b.sig;

        exp_p    = $signed({4'd0, req.a.fields.exponent})
                 + $signed({4'd0, req.b.fields.exponent}) - 12'sd127;
        exp_c    = $signed({4'd0, req.c.fields.exponent});
        exp_diff = exp_p - exp_c;

        // A zero term never anchors the sum.
        prod_big = op_c.zero | (!prod_zero && exp_diff >= 0);
        exp_abs  = prod_big ? exp_diff : -exp_diff;
        shamt    = (exp_abs < 0 || exp_abs > 12'sd75) ? 7'd76 : 7'(exp_abs);

        frame_p     = {prod_sig, 28'd0};
        frame_c     = {1'b0, op_c.sig, 51'd0};
        frame_small = prod_big ? frame_c : frame_p;
        shifted     = frame_small >> shamt;
        lost        = frame_small << (7'd76 - shamt);
    end

    logic [FW-1:0]      s1_big, s1_small;
    logic               s1_sub, s1_sign, s1_zero_sign;
    logic signed [11:0] s1_exp;
    logic               s1_nan, s1_nv, s1_inf, s1_inf_sign;
    frm_t               s1_frm;

    always_ff @(posedge clk) begin
        if (enable) begin
            s1_big       <= prod_big ? frame_p : frame_c;
            s1_small     <= {shifted[FW-1:1], shifted[0] | (|lost)};
            s1_sub       <= sign_p ^ sign_c;
            s1_sign      <= prod_big ? sign_p : sign_c;
            s1_zero_sign <= sign_p & sign_c;
            s1_exp       <= prod_big ? exp_p : exp_c;
            s1_nan       <= prod_nan | op_c.nan | (prod_inf & op_c.inf & (sign_p ^ sign_c));
            s1_nv        <= op_a.snan | op_b.snan | op_c.snan
                          | (op_a.inf & op_b.zero) | (op_a.zero & op_b.inf)
                          | (prod_inf & op_c.inf & (sign_p ^ sign_c));
            s1_inf       <= prod_inf | op_c.inf;
            s1_inf_sign  <= prod_inf ? sign_p : sign_c;
            s1_frm       <= req.frm;
        end
    end

    ////////////////////
    // Stage 2: add, normalize, round

    logic [FW:0]        sum, mag, norm;
    logic               neg, res_sign;
    logic [6:0]         lz;
    logic signed [11:0] exp_n, exp_r;
    logic [24:0]        sig_r;
    logic               guard, sticky, inc;
    fp32_t              res_d;
    fflags_t            flags_d;

    always_comb begin
        sum = s1_sub ? ({1'b0, s1_big} - {1'b0, s1_small})
                     : ({1'b0, s1_big} + {1'b0, s1_small});
        neg      = s1_sub & sum[FW];
        mag      = neg ? -sum : sum;
        res_sign = s1_sign ^ neg;

        // The leading one lands on bit FW, so the exponent moves by 2 - lz.
        lz    = count_lz(mag);
        norm  = mag << lz;
        exp_n = s1_exp + 12'sd2 - $signed({5'd0, lz});

        guard  = norm[52];
        sticky = |norm[51:0];
        inc    = (s1_frm != RTZ) && guard && (sticky || norm[53]);
        sig_r  = {1'b0, norm[FW:53]} + 25'(inc);
        exp_r  = exp_n + $signed({11'd0, sig_r[24]});

        res_d.raw  = {res_sign, exp_r[7:0], sig_r[22:0]};
        flags_d    = '0;
        flags_d.nx = guard | sticky;

        if (s1_nan) begin
            res_d.raw  = FP32_QNAN;
            flags_d    = '0;
            flags_d.nv = s1_nv;
        end else if (s1_inf) begin
            res_d.raw = {s1_inf_sign, 8'hff, 23'd0};
            flags_d   = '0;
        end else if (mag == '0) begin
            // Exact zero, negative only when both terms are negative.
            res_d.raw = {s1_zero_sign, 31'd0};
            flags_d   = '0;
        end else if (exp_r >= 12'sd255) begin
            if (s1_frm == RTZ) begin
                res_d.raw = {res_sign, 8'hfe, 23'h7fffff};
            end else begin
                res_d.raw = {res_sign, 8'hff, 23'd0};
            end
            flags_d.of = 1'b1;
            flags_d.nx = 1'b1;
        end else if (exp_r <= 12'sd0) begin
            res_d.raw  = {res_sign, 31'd0};
            flags_d.uf = 1'b1;
            flags_d.nx = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            result <= res_d;
            fflags <= flags_d;
        end
    end

endmodule

// ==== fp_result_merge.sv ====
module fp_result_merge import fp_pkg::*; #(
    parameter int LANES = 4,
    parameter int TAGW  = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ready_out,
    input  logic                  valid_in,
    input  logic [TAGW-1:0]       tag_in,
    input  fflags_t [LANES-1:0]   lane_flags,
    output logic                  enable,
    output logic                  valid_out,
    output logic [TAGW-1:0]       tag_out,
    output logic                  has_fflags
);

    logic [FMA_LATENCY-1:0]           valid_q;
    logic [FMA_LATENCY-1:0][TAGW-1:0] tag_q;

    // The whole pipeline freezes while a result waits at the output.
    assign enable = ~(valid_out & ~ready_out);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (enable) begin
            valid_q <= {valid_q[FMA_LATENCY-2:0], valid_in};
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            tag_q <= {tag_q[FMA_LATENCY-2:0], tag_in};
        end
    end

    assign valid_out = valid_q[FMA_LATENCY-1];
    assign tag_out   = tag_q[FMA_LATENCY-1];

    // Flags of an empty slot are stale and must not show.
    assign has_fflags = valid_out & (|lane_flags);

endmodule

// ==== fp_fma_unit.sv ====
module fp_fma_unit import fp_pkg::*; #(
    parameter int LANES = 4,
    parameter int TAGW  = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  valid_in,
    output logic                  ready_in,
    input  logic [TAGW-1:0]       tag_in,
    input  fp_op_t                op,
    input  frm_t                  frm,
    input  fp32_t   [LANES-1:0]   dataa,
    input  fp32_t   [LANES-1:0]   datab,
    input  fp32_t   [LANES-1:0]   datac,
    output fp32_t   [LANES-1:0]   result,
    output fflags_t [LANES-1:0]   fflags,
    output logic                  has_fflags,
    output logic [TAGW-1:0]       tag_out,
    input  logic                  ready_out,
    output logic                  valid_out
);

    logic                    enable;
    lane_req_t [LANES-1:0]   req;

    assign ready_in = enable;

    fp_operand_fmt #(
        .LANES (LANES)
    ) i_fp_operand_fmt (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .op     (op),
        .frm    (frm),
        .dataa  (dataa),
        .datab  (datab),
        .datac  (datac),
        .req    (req)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        fp_fma_lane i_fp_fma_lane (
            .clk    (clk),
            .enable (enable),
            .req    (req[i]),
            .result (result[i]),
            .fflags (fflags[i])
        );
    end

    fp_result_merge #(
        .LANES (LANES),
        .TAGW  (TAGW)
    ) i_fp_result_merge (
        .clk        (clk),
        .rst        (rst),
        .ready_out  (ready_out),
        .valid_in   (valid_in),
        .tag_in     (tag_in),
        .lane_flags (fflags),
        .enable     (enable),
        .valid_out  (valid_out),
        .tag_out    (tag_out),
        .has_fflags (has_fflags)
    );

endmodule

// ==== tb_fp_fma_unit.sv ====
module tb_fp_fma_unit import fp_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int LANES          = 4;
    localparam int TAGW           = 4;
    localparam int CLK_PERIOD     = 100;
    localparam int NUM_ENTRIES    = 26;
    localparam int PASSES         = 4;
    localparam int TIMEOUT_CYCLES = NUM_ENTRIES * PASSES * 20 + 100;

    typedef struct packed {
        fp_op_t      op;
        frm_t        frm;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] res;
        fflags_t     flags;
    } vector_t;

    typedef struct packed {
        logic [TAGW-1:0]      tag;
        fp32_t [LANES-1:0]    result;
        fflags_t [LANES-1:0]  flags;
        logic [31:0]          cyc;
    } expect_t;

    logic                 clk;
    logic                 rst;
    logic                 valid_in;
    logic                 ready_in;
    logic [TAGW-1:0]      tag_in;
    fp_op_t               op;
    frm_t                 frm;
    fp32_t   [LANES-1:0]  dataa;
    fp32_t   [LANES-1:0]  datab;
    fp32_t   [LANES-1:0]  datac;
    fp32_t   [LANES-1:0]  result;
    fflags_t [LANES-1:0]  fflags;
    logic                 has_fflags;
    logic [TAGW-1:0]      tag_out;
    logic                 ready_out;
    logic                 valid_out;

    vector_t     vectors [NUM_ENTRIES];
    expect_t     pending [$];
    expect_t     next_expect;
    logic [31:0] cycle;
    int          next_index;

    fp_fma_unit #(
        .LANES (LANES),
        .TAGW  (TAGW)
    ) i_fp_fma_unit (
        .clk        (clk),
        .rst        (rst),
        .valid_in   (valid_in),
        .ready_in   (ready_in),
        .tag_in     (tag_in),
        .op         (op),
        .frm        (frm),
        .dataa      (dataa),
        .datab      (datab),
        .datac      (datac),
        .result     (result),
        .fflags     (fflags),
        .has_fflags (has_fflags),
        .tag_out    (tag_out),
        .ready_out  (ready_out),
        .valid_out  (valid_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Error: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("Regression failed");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Error: %s is 0x%h, expected 0x%h", name, got, expected);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic set_vector(input int idx, input fp_op_t v_op, input frm_t v_frm,
                              input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] c, input logic [31:0] res,
                              input fflags_t flags);
        vectors[idx] = '{v_op, v_frm, a, b, c, res, flags};
    endtask

    ////////////////////
    // Vectors

    // Flag bits are nv, dz, of, uf, nx. Entries sharing op and frm sit together.
    task automatic load_vectors();
        set_vector(0,  ADD,   RNE, 32'h3f800000, 32'h40000000, 32'h0, 32'h40400000, 5'b00000);
        set_vector(1,  ADD,   RNE, 32'h00400000, 32'h3f800000, 32'h0, 32'h3f800000, 5'b00000);
        set_vector(2,  ADD,   RNE, 32'h3f800001, 32'h33800000, 32'h0, 32'h3f800002, 5'b00001);
        set_vector(3,  ADD,   RNE, 32'h3f800000, 32'h33800000, 32'h0, 32'h3f800000, 5'b00001);
        set_vector(4,  ADD,   RNE, 32'h7f800001, 32'h3f800000, 32'h0, 32'h7fc00000, 5'b10000);
        set_vector(5,  ADD,   RNE, 32'h7f800000, 32'hff800000, 32'h0, 32'h7fc00000, 5'b10000);
        set_vector(6,  ADD,   RTZ, 32'h3f800001, 32'h33800000, 32'h0, 32'h3f800001, 5'b00001);
        set_vector(7,  SUB,   RTZ, 32'h40a00000, 32'h40400000, 32'h0, 32'h40000000, 5'b00000);
        set_vector(8,  SUB,   RTZ, 32'h3fc00000, 32'h3fc00000, 32'h0, 32'h00000000, 5'b00000);
        set_vector(9,  MUL,   RNE, 32'h40400000, 32'h40800000, 32'h0, 32'h41400000, 5'b00000);
        set_vector(10, MUL,   RNE, 32'h80400000, 32'h40000000, 32'h0, 32'h80000000, 5'b00000);
        set_vector(11, MUL,   RNE, 32'h7f800000, 32'h00000000, 32'h0, 32'h7fc00000, 5'b10000);
        set_vector(12, MUL,   RNE, 32'h7f000000, 32'h40000000, 32'h0, 32'h7f800000, 5'b00101);
        set_vector(13, MUL,   RNE, 32'h1f800000, 32'h1f800000, 32'h0, 32'h00000000, 5'b00011);
        set_vector(14, MUL,   RTZ, 32'h7f000000, 32'h40000000, 32'h0, 32'h7f7fffff, 5'b00101);
        set_vector(15, MUL,   RTZ, 32'h7fc00000, 32'h3f800000, 32'h0, 32'h7fc00000, 5'b00000);
        set_vector(16, MADD,  RNE, 32'h40000000, 32'h40400000, 32'h3f800000, 32'h40e00000,
                   5'b00000);
        // Rounding the product first would lose the 2^-24 term.
        set_vector(17, MADD,  RNE, 32'h3f800800, 32'h3f800800, 32'hbf800000, 32'h3a000400,
                   5'b00000);
        set_vector(18, MSUB,  RTZ, 32'h40000000, 32'h40400000, 32'h3f800000, 32'h40a00000,
                   5'b00000);
        set_vector(19, NMADD, RNE, 32'h40000000, 32'h40400000, 32'h3f800000, 32'hc0e00000,
                   5'b00000);
        set_vector(20, NMSUB, RNE, 32'h40000000, 32'h40400000, 32'h3f800000, 32'hc0a00000,
                   5'b00000);
        // The 1 + 2^-23 + 2^-24 tie again, reached through the other operations.
        set_vector(21, SUB,   RNE, 32'h3f800001, 32'hb3800000, 32'h0, 32'h3f800002, 5'b00001);
        set_vector(22, MADD,  RTZ, 32'h3f800001, 32'h3f800000, 32'h33800000, 32'h3f800001,
                   5'b00001);
        set_vector(23, MSUB,  RNE, 32'h3f800001, 32'h3f800000, 32'hb3800000, 32'h3f800002,
                   5'b00001);
        set_vector(24, NMADD, RTZ, 32'h3f800001, 32'h3f800000, 32'h33800000, 32'hbf800001,
                   5'b00001);
        set_vector(25, NMSUB, RTZ, 32'h3f800001, 32'h3f800000, 32'hb3800000, 32'hbf800001,
                   5'b00001);
    endtask

    ////////////////////
    // Driving and checking

    task automatic drive_request(input int k);
        vector_t base;
        vector_t v;
        int      j;
        base = vectors[k % NUM_ENTRIES];
        op = base.op;
        frm = base.frm;
        tag_in = TAGW'(k);
        next_expect.tag = TAGW'(k);
        for (int i = 0; i < LANES; i++) begin
            j = (k + i) % NUM_ENTRIES;
            v = vectors[j];
            // All lanes share one op and rounding mode, so a mismatching entry falls back.
            if (v.op != base.op || v.frm != base.frm) begin
                v = base;
            end
            dataa[i].raw = v.a;
            datab[i].raw = v.b;
            datac[i].raw = v.c;
            next_expect.result[i].raw = v.res;
            next_expect.flags[i] = v.flags;
        end
    endtask

    task automatic observe_outputs(input bit check_latency);
        expect_t exp;
        logic    any_flag;
        if (valid_out !== 1'b1) begin
            check_value("valid_out", 32'(valid_out), 32'd0);
            check_value("has_fflags", 32'(has_fflags), 32'd0);
        end else if (pending.size() == 0) begin
            $display("Error: a result came out while no request was pending");
            $display("Regression failed");
            $fatal(1, "unexpected result");
        end else begin
            exp = pending[0];
            any_flag = 1'b0;
            check_value("tag_out", 32'(tag_out), 32'(exp.tag));
            for (int i = 0; i < LANES; i++) begin
                check_value($sformatf("result[%0d]", i), result[i].raw, exp.result[i].raw);
                check_value($sformatf("fflags[%0d]", i), 32'(fflags[i]), 32'(exp.flags[i]));
                any_flag = any_flag | (|exp.flags[i]);
            end
            check_value("has_fflags", 32'(has_fflags), 32'(any_flag));
            if (check_latency) begin
                check_value("latency", cycle - exp.cyc, 32'(FMA_LATENCY));
            end
            if (ready_out) begin
                void'(pending.pop_front());
            end
        end
    endtask

    // Each pass through the loop is one clock; handshakes are judged after the inputs settle.
    task automatic run_requests(input int count, input bit back_pressure);
        int sent;
        sent = 0;
        while (sent < count || pending.size() > 0) begin
            @(negedge clk);
            cycle = cycle + 1;
            ready_out = back_pressure ? (($urandom % 100) < 60) : 1'b1;
            if (sent < count && (!back_pressure || ($urandom % 4) != 0)) begin
                drive_request(next_index);
                valid_in = 1'b1;
            end else begin
                valid_in = 1'b0;
            end
            #1;
            observe_outputs(!back_pressure);
            check_value("ready_in", 32'(ready_in), 32'(!(valid_out && !ready_out)));
            if (valid_in && ready_in) begin
                next_expect.cyc = cycle;
                pending.push_back(next_expect);
                next_index++;
                sent++;
            end
        end
    endtask

    initial begin
        void'($urandom(84));
        load_vectors();
        clk = 1'b0;
        rst = 1'b1;
        valid_in = 1'b0;
        tag_in = '0;
        op = ADD;
        frm = RNE;
        dataa = '0;
        datab = '0;
        datac = '0;
        ready_out = 1'b0;
        cycle = '0;
        next_index = 0;

        repeat (3) begin
            @(negedge clk);
            check_value("valid_out", 32'(valid_out), 32'd0);
            check_value("ready_in", 32'(ready_in), 32'd1);
        end
        rst = 1'b0;
        @(negedge clk);
        check_value("valid_out", 32'(valid_out), 32'd0);
        check_value("ready_in", 32'(ready_in), 32'd1);

        run_requests(NUM_ENTRIES, 1'b0);
        run_requests(NUM_ENTRIES * (PASSES - 1), 1'b1);

        // A duplicated result would show up here.
        repeat (FMA_LATENCY + 1) begin
            @(negedge clk);
            ready_out = 1'b1;
            valid_in = 1'b0;
            #1;
            check_value("valid_out", 32'(valid_out), 32'd0);
        end

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== tb.f ====
fp_pkg.sv
fp_operand_fmt.sv
fp_fma_lane.sv
fp_result_merge.sv
fp_fma_unit.sv
tb_fp_fma_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_fp_fma_unit
FILELIST  := tb.f
OBJ_DIR   := obj_dir
PASS_MSG  := Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run the regression"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
